/* hw/dex_pkg.sv */
package dex_pkg;

	// Opcode in instr[15:11], ALU ops share the low three bits with alu_op_e
	typedef enum logic [4:0] {
		OP_ADD  = 5'b00000,
		OP_SUB  = 5'b00001,
		OP_AND  = 5'b00010,
		OP_OR   = 5'b00011,
		OP_XOR  = 5'b00100,
		OP_SLL  = 5'b00101,
		OP_SRL  = 5'b00110,
		OP_SRA  = 5'b00111,
		OP_LDL  = 5'b01000,
		OP_LDU  = 5'b01001,
		OP_LD   = 5'b01010,
		OP_ST   = 5'b01011,
		OP_B    = 5'b01100,
		OP_J    = 5'b01101,
		OP_WAIT = 5'b01110,
		OP_VPU  = 5'b01111,
		OP_NOP  = 5'b11111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLL = 3'd5,
		ALU_SRL = 3'd6,
		ALU_SRA = 3'd7
	} alu_op_e;

	typedef struct packed {
		logic z;
		logic n;
		logic v;
	} flags_t;

	// Same bit order as flags_t
	typedef struct packed {
		logic z_we;
		logic n_we;
		logic v_we;
	} flags_we_t;

	typedef struct packed {
		logic      alu_to_reg;
		logic      pcr_to_reg;
		logic      mem_to_reg;
		logic      reg_we_dst_0;
		logic      reg_we_dst_1;
		logic      mem_we;
		logic      mem_re;
		logic      add_immd;
		logic      jump_immd;
		logic      ldu;
		logic      ldl;
		logic      branch;
		logic      jump;
		flags_we_t flags_we;
	} dex_ctrl_t;

	typedef struct packed {
		logic        we;
		logic [4:0]  addr;
		logic [15:0] data;
	} wr_port_t;

	// Stage register toward memory/writeback
	typedef struct packed {
		logic        alu_to_reg;
		logic        pcr_to_reg;
		logic        mem_to_reg;
		logic        reg_we_dst_0;
		logic        reg_we_dst_1;
		logic        mem_we;
		logic        mem_re;
		logic [4:0]  dst_addr_0;
		logic [4:0]  dst_addr_1;
		logic [15:0] alu_result;
		logic [15:0] pc_return;
		logic [15:0] mem_addr;
		logic [15:0] mem_wdata;
		logic [15:0] load_immd;
	} dex_mwb_t;

	// Receives the return address of J
	localparam logic [4:0] LINK_REG = 5'd16;

endpackage

/* hw/alu.sv */
`timescale 1ns/1ps

module alu import dex_pkg::*; (
	input  logic [15:0] op0,
	input  logic [15:0] op1,
	input  alu_op_e     op,
	input  logic [3:0]  shamt,
	output logic [15:0] result,
	output flags_t      flags
);

	logic add_ovf;
	logic sub_ovf;

	always_comb begin
		case (op)
			ALU_ADD: result = op0 + op1;
			ALU_SUB: result = op0 - op1;
			ALU_AND: result = op0 & op1;
			ALU_OR:  result = op0 | op1;
			ALU_XOR: result = op0 ^ op1;
			ALU_SLL: result = op0 << shamt;
			ALU_SRL: result = op0 >> shamt;
			ALU_SRA: result = $unsigned($signed(op0) >>> shamt);
			default: result = '0;
		endcase
	end

	//////////////////////////////
	// Flags
	//////////////////////////////
	// Signed overflow, operands alike in sign but result differs
	assign add_ovf = (op0[15] == op1[15]) && (result[15] != op0[15]);
	// Subtract flips the sign test on op1
	assign sub_ovf = (op0[15] != op1[15]) && (result[15] != op0[15]);

	always_comb begin
		flags.z = (result == 16'h0000);
		flags.n = result[15];
		case (op)
			ALU_ADD: flags.v = add_ovf;
			ALU_SUB: flags.v = sub_ovf;
			default: flags.v = 1'b0;
		endcase
	end

endmodule

/* hw/register_file.sv */
`timescale 1ns/1ps

module register_file import dex_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [4:0]  rd_addr_0,
	input  logic [4:0]  rd_addr_1,
	input  wr_port_t    wr_0,
	input  wr_port_t    wr_1,
	output logic [15:0] rd_data_0,
	output logic [15:0] rd_data_1
);

	logic [15:0] regs [32];

	//////////////////////////////
	// Write ports
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wr_0.we)
				regs[wr_0.addr] <= wr_0.data;
			// Port 1 last so it wins on a same-address write
			if (wr_1.we)
				regs[wr_1.addr] <= wr_1.data;
		end
	end

	// Asynchronous reads, no write bypass
	assign rd_data_0 = regs[rd_addr_0];
	assign rd_data_1 = regs[rd_addr_1];

endmodule

/* hw/control_unit.sv */
`timescale 1ns/1ps

module control_unit import dex_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        stall_memory,
	input  opcode_e     opcode,
	input  logic        x_bit,
	input  logic [10:0] wait_time,
	input  logic        vpu_rdy,
	output dex_ctrl_t   ctrl,
	output logic        stall_control,
	output logic        vpu_start
);

	logic [10:0] wait_cnt;
	logic        wait_done;
	logic        stall_wait;
	logic        stall_vpu;

	//////////////////////////////
	// Opcode decode
	//////////////////////////////
	always_comb begin
		ctrl = '0;
		case (opcode)
			OP_ADD, OP_SUB: begin
				ctrl.alu_to_reg      = 1'b1;
				ctrl.reg_we_dst_0    = 1'b1;
				ctrl.add_immd        = x_bit;
				ctrl.flags_we.z_we   = 1'b1;
				ctrl.flags_we.n_we   = 1'b1;
				ctrl.flags_we.v_we   = 1'b1;
			end
			OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA: begin
				ctrl.alu_to_reg      = 1'b1;
				ctrl.reg_we_dst_0    = 1'b1;
				// V is left alone by logic and shifts
				ctrl.flags_we.z_we   = 1'b1;
				ctrl.flags_we.n_we   = 1'b1;
			end
			OP_LDL: begin
				ctrl.ldl          = 1'b1;
				ctrl.reg_we_dst_0 = 1'b1;
			end
			OP_LDU: begin
				ctrl.ldu          = 1'b1;
				ctrl.reg_we_dst_0 = 1'b1;
			end
			OP_LD: begin
				ctrl.mem_re       = 1'b1;
				ctrl.mem_to_reg   = 1'b1;
				ctrl.reg_we_dst_0 = 1'b1;
			end
			OP_ST: ctrl.mem_we = 1'b1;
			OP_B:  ctrl.branch = 1'b1;
			OP_J: begin
				ctrl.jump         = 1'b1;
				ctrl.jump_immd    = x_bit;
				ctrl.pcr_to_reg   = 1'b1;
				ctrl.reg_we_dst_1 = 1'b1;
			end
			default: ;
		endcase
	end

	//////////////////////////////
	// WAIT stretching
	//////////////////////////////
	// Stall until the counter has run out, zero count never stalls
	assign stall_wait = (opcode == OP_WAIT) && !wait_done && (wait_time != 11'd0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wait_cnt  <= '0;
			wait_done <= 1'b0;
		end else if (!stall_memory && opcode == OP_WAIT) begin
			if (stall_wait) begin
				wait_cnt <= wait_cnt + 11'd1;
				if (wait_cnt + 11'd1 == wait_time)
					wait_done <= 1'b1;
			end else begin
				// Word advances here, rearm for a following WAIT
				wait_cnt  <= '0;
				wait_done <= 1'b0;
			end
		end
	end

	// Vector unit handshake
	assign vpu_start = (opcode == OP_VPU);
	assign stall_vpu = vpu_start && !vpu_rdy;

	assign stall_control = stall_wait | stall_vpu;

endmodule

/* hw/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit import dex_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        stall,
	input  logic        branch,
	input  logic        jump,
	input  logic        jump_immd,
	input  logic [2:0]  cond,
	input  flags_we_t   flags_we,
	input  flags_t      alu_flags,
	input  logic [15:0] pc_plus_1,
	input  logic [15:0] branch_offset,
	input  logic [15:0] jump_operand,
	output logic        pc_select,
	output logic [15:0] pc_next,
	output logic [15:0] pc_return
);

	flags_t flags_q;
	logic   taken;

	//////////////////////////////
	// Flag register
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flags_q <= '0;
		end else if (!stall) begin
			if (flags_we.z_we)
				flags_q.z <= alu_flags.z;
			if (flags_we.n_we)
				flags_q.n <= alu_flags.n;
			if (flags_we.v_we)
				flags_q.v <= alu_flags.v;
		end
	end

	// Condition codes 0..7
	always_comb begin
		case (cond)
			3'd0: taken = !flags_q.z;
			3'd1: taken = flags_q.z;
			3'd2: taken = !flags_q.z && !flags_q.n;
			3'd3: taken = flags_q.n;
			3'd4: taken = !flags_q.n;
			3'd5: taken = flags_q.z || flags_q.n;
			3'd6: taken = flags_q.v;
			default: taken = 1'b1;
		endcase
	end

	assign pc_select = (branch && taken) || jump;

	// Register-form jump goes straight to Rt
	always_comb begin
		if (jump && !jump_immd)
			pc_next = jump_operand;
		else if (jump)
			pc_next = pc_plus_1 + jump_operand;
		else
			pc_next = pc_plus_1 + branch_offset;
	end

	assign pc_return = pc_plus_1;

endmodule

/* hw/decode_execute.sv */
`timescale 1ns/1ps

module decode_execute import dex_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        stall_memory,
	input  logic [15:0] instr,
	input  logic [15:0] pc_plus_1,
	input  wr_port_t    wr_0,
	input  wr_port_t    wr_1,
	input  logic        vpu_rdy,
	output logic        stall,
	output logic        pc_select,
	output logic        vpu_start,
	output logic [15:0] pc_next,
	output dex_mwb_t    mwb
);

	dex_ctrl_t   ctrl;
	logic        stall_control;
	logic [4:0]  rd_addr_0;
	logic [4:0]  rd_addr_1;
	logic [15:0] rd_data_0;
	logic [15:0] rd_data_1;
	logic [15:0] alu_op1;
	logic [15:0] alu_result;
	flags_t      alu_flags;
	logic [15:0] branch_offset;
	logic [15:0] jump_operand;
	logic [15:0] pc_return;
	dex_mwb_t    mwb_d;

	control_unit control_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall_memory  (stall_memory),
		.opcode        (opcode_e'(instr[15:11])),
		.x_bit         (instr[10]),
		.wait_time     (instr[10:0]),
		.vpu_rdy       (vpu_rdy),
		.ctrl          (ctrl),
		.stall_control (stall_control),
		.vpu_start     (vpu_start)
	);

	assign stall = stall_control | stall_memory;

	// LDL and LDU name their register in bits 10..8
	assign rd_addr_0 = (ctrl.ldu || ctrl.ldl) ? {2'b00, instr[10:8]} : instr[9:5];
	assign rd_addr_1 = instr[4:0];

	register_file regfile_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr_0 (rd_addr_0),
		.rd_addr_1 (rd_addr_1),
		.wr_0      (wr_0),
		.wr_1      (wr_1),
		.rd_data_0 (rd_data_0),
		.rd_data_1 (rd_data_1)
	);

	// 5-bit immediate in the Rt field
	assign alu_op1 = ctrl.add_immd ? {{11{instr[4]}}, instr[4:0]} : rd_data_1;

	alu alu_i (
		.op0    (rd_data_0),
		.op1    (alu_op1),
		.op     (alu_op_e'(instr[13:11])),
		.shamt  (instr[3:0]),
		.result (alu_result),
		.flags  (alu_flags)
	);

	assign branch_offset = {{8{instr[7]}}, instr[7:0]};
	assign jump_operand  = ctrl.jump_immd ? {{6{instr[9]}}, instr[9:0]} : rd_data_1;

	branch_unit branch_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall         (stall),
		.branch        (ctrl.branch),
		.jump          (ctrl.jump),
		.jump_immd     (ctrl.jump_immd),
		.cond          (instr[10:8]),
		.flags_we      (ctrl.flags_we),
		.alu_flags     (alu_flags),
		.pc_plus_1     (pc_plus_1),
		.branch_offset (branch_offset),
		.jump_operand  (jump_operand),
		.pc_select     (pc_select),
		.pc_next       (pc_next),
		.pc_return     (pc_return)
	);

	//////////////////////////////
	// Stage register
	//////////////////////////////
	always_comb begin
		mwb_d.alu_to_reg   = ctrl.alu_to_reg;
		mwb_d.pcr_to_reg   = ctrl.pcr_to_reg;
		mwb_d.mem_to_reg   = ctrl.mem_to_reg;
		mwb_d.reg_we_dst_0 = ctrl.reg_we_dst_0;
		mwb_d.reg_we_dst_1 = ctrl.reg_we_dst_1;
		mwb_d.mem_we       = ctrl.mem_we;
		mwb_d.mem_re       = ctrl.mem_re;
		mwb_d.dst_addr_0   = rd_addr_0;
		mwb_d.dst_addr_1   = ctrl.jump ? LINK_REG : rd_addr_1;
		mwb_d.alu_result   = alu_result;
		mwb_d.pc_return    = pc_return;
		mwb_d.mem_addr     = rd_data_1;
		mwb_d.mem_wdata    = rd_data_0;
		// Merge the byte into the old register value
		mwb_d.load_immd    = ctrl.ldu ? {instr[7:0], rd_data_0[7:0]}
			: {rd_data_0[15:8], instr[7:0]};
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			mwb <= '0;
		else if (!stall)
			mwb <= mwb_d;
	end

endmodule

/* bench/tb_decode_execute.sv */
`timescale 1ns/1ps

module tb_decode_execute import dex_pkg::*; ();

	localparam logic [15:0] NOP_WORD = 16'hf800;
	localparam logic [15:0] VPU_WORD = 16'h7800;

	// Cycle budget per test
	localparam int RESET_CYCLES  = 10;
	localparam int REGS_CYCLES   = 44;
	localparam int ALU_CYCLES    = 24;
	localparam int BRANCH_CYCLES = 76;
	localparam int JMEM_CYCLES   = 16;
	localparam int STALL_CYCLES  = 34;
	localparam int CYCLE_LIMIT   = 2 * (RESET_CYCLES + REGS_CYCLES + ALU_CYCLES
		+ BRANCH_CYCLES + JMEM_CYCLES + STALL_CYCLES);

	logic        clk;
	logic        rst_n;
	logic        stall_memory;
	logic [15:0] instr;
	logic [15:0] pc_plus_1;
	wr_port_t    wr_0;
	wr_port_t    wr_1;
	logic        vpu_rdy;
	logic        stall;
	logic        pc_select;
	logic        vpu_start;
	logic [15:0] pc_next;
	dex_mwb_t    mwb;

	// Reference state
	logic [15:0] ref_regs [32];
	flags_t      ref_flags;
	dex_mwb_t    last_exp;
	dex_mwb_t    last_care;
	logic [31:0] seed = 32'h8162_1f4b;
	int          checks = 0;
	int          errors = 0;
	int          cycles = 0;

	decode_execute dut_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.stall_memory (stall_memory),
		.instr        (instr),
		.pc_plus_1    (pc_plus_1),
		.wr_0         (wr_0),
		.wr_1         (wr_1),
		.vpu_rdy      (vpu_rdy),
		.stall        (stall),
		.pc_select    (pc_select),
		.vpu_start    (vpu_start),
		.pc_next      (pc_next),
		.mwb          (mwb)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
			$display("TESTS FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////
	function automatic logic [15:0] lcg16();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[31:16];
	endfunction

	function automatic logic [15:0] alu_ref(input alu_op_e op, input logic [15:0] a,
		input logic [15:0] b, input logic [3:0] sh, output flags_t f);
		logic [15:0] r;
		int sa;
		int sb;
		int sum;
		sa = int'($signed(a));
		sb = int'($signed(b));
		sum = (op == ALU_ADD) ? sa + sb : sa - sb;
		case (op)
			ALU_ADD: r = a + b;
			ALU_SUB: r = a - b;
			ALU_AND: r = a & b;
			ALU_OR:  r = a | b;
			ALU_XOR: r = a ^ b;
			ALU_SLL: r = a << sh;
			ALU_SRL: r = a >> sh;
			default: begin
				r = a >> sh;
				// Fill vacated bits with the sign
				if (a[15])
					r = r | ~(16'hffff >> sh);
			end
		endcase
		f.z = (r == 16'h0000);
		f.n = r[15];
		f.v = (op == ALU_ADD || op == ALU_SUB) && (sum > 32767 || sum < -32768);
		return r;
	endfunction

	task automatic update_flags(input alu_op_e op, input flags_t f);
		ref_flags.z = f.z;
		ref_flags.n = f.n;
		if (op == ALU_ADD || op == ALU_SUB)
			ref_flags.v = f.v;
	endtask

	function automatic logic taken_ref(input logic [2:0] cond);
		case (cond)
			3'd0: return !ref_flags.z;
			3'd1: return ref_flags.z;
			3'd2: return !ref_flags.z && !ref_flags.n;
			3'd3: return ref_flags.n;
			3'd4: return !ref_flags.n;
			3'd5: return ref_flags.z || ref_flags.n;
			3'd6: return ref_flags.v;
			default: return 1'b1;
		endcase
	endfunction

	// Care mask with only the seven controls
	function automatic dex_mwb_t ctrl_care();
		dex_mwb_t c;
		c = '0;
		{c.alu_to_reg, c.pcr_to_reg, c.mem_to_reg, c.reg_we_dst_0,
			c.reg_we_dst_1, c.mem_we, c.mem_re} = '1;
		return c;
	endfunction

	//////////////////////////////
	// Compare tasks
	//////////////////////////////
	task automatic cmp_field(input string name, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %s exp %h got %h", name, exp, act);
		end
	endtask

	task automatic check_mwb(input dex_mwb_t exp, input dex_mwb_t care);
		dex_mwb_t e;
		dex_mwb_t a;
		e = exp & care;
		a = mwb & care;
		cmp_field("mwb.alu_to_reg", 16'(e.alu_to_reg), 16'(a.alu_to_reg));
		cmp_field("mwb.pcr_to_reg", 16'(e.pcr_to_reg), 16'(a.pcr_to_reg));
		cmp_field("mwb.mem_to_reg", 16'(e.mem_to_reg), 16'(a.mem_to_reg));
		cmp_field("mwb.reg_we_dst_0", 16'(e.reg_we_dst_0), 16'(a.reg_we_dst_0));
		cmp_field("mwb.reg_we_dst_1", 16'(e.reg_we_dst_1), 16'(a.reg_we_dst_1));
		cmp_field("mwb.mem_we", 16'(e.mem_we), 16'(a.mem_we));
		cmp_field("mwb.mem_re", 16'(e.mem_re), 16'(a.mem_re));
		cmp_field("mwb.dst_addr_0", 16'(e.dst_addr_0), 16'(a.dst_addr_0));
		cmp_field("mwb.dst_addr_1", 16'(e.dst_addr_1), 16'(a.dst_addr_1));
		cmp_field("mwb.alu_result", e.alu_result, a.alu_result);
		cmp_field("mwb.pc_return", e.pc_return, a.pc_return);
		cmp_field("mwb.mem_addr", e.mem_addr, a.mem_addr);
		cmp_field("mwb.mem_wdata", e.mem_wdata, a.mem_wdata);
		cmp_field("mwb.load_immd", e.load_immd, a.load_immd);
	endtask

	task automatic check_pc(input logic exp_sel, input logic [15:0] exp_next);
		cmp_field("pc_select", 16'(exp_sel), 16'(pc_select));
		cmp_field("pc_next", exp_next, pc_next);
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		cmp_field(name, 16'(exp), 16'(act));
	endtask

	//////////////////////////////
	// Drivers
	//////////////////////////////
	task automatic drive_word(input logic [15:0] w);
		@(negedge clk);
		instr = w;
		pc_plus_1 = lcg16();
		#1;
	endtask

	task automatic expect_advance(input dex_mwb_t exp, input dex_mwb_t care);
		@(posedge clk);
		#1;
		check_mwb(exp, care);
		last_exp = exp;
		last_care = care;
	endtask

	task automatic write_pair(input logic [4:0] a0, input logic [15:0] d0,
		input logic [4:0] a1, input logic [15:0] d1);
		@(negedge clk);
		instr = NOP_WORD;
		wr_0 = {1'b1, a0, d0};
		wr_1 = {1'b1, a1, d1};
		@(negedge clk);
		wr_0 = '0;
		wr_1 = '0;
		ref_regs[a0] = d0;
		// Port 1 wins a collision
		ref_regs[a1] = d1;
	endtask

	task automatic run_alu(input alu_op_e op, input logic x, input logic [4:0] rs,
		input logic [4:0] rt);
		logic [15:0] b;
		flags_t f;
		dex_mwb_t exp;
		dex_mwb_t care;
		b = x ? {{11{rt[4]}}, rt} : ref_regs[rt];
		exp = '0;
		exp.alu_to_reg = 1'b1;
		exp.reg_we_dst_0 = 1'b1;
		exp.dst_addr_0 = rs;
		exp.alu_result = alu_ref(op, ref_regs[rs], b, rt[3:0], f);
		care = ctrl_care();
		care.dst_addr_0 = '1;
		care.alu_result = '1;
		drive_word({2'b00, op, x, rs, rt});
		check_bit("stall", 1'b0, stall);
		check_bit("pc_select", 1'b0, pc_select);
		expect_advance(exp, care);
		update_flags(op, f);
	endtask

	task automatic run_branch(input logic [2:0] cond, input logic [7:0] off);
		drive_word({5'b01100, cond, off});
		check_pc(taken_ref(cond), pc_plus_1 + {{8{off[7]}}, off});
		expect_advance('0, ctrl_care());
	endtask

	task automatic run_jump(input logic immd, input logic [9:0] field);
		dex_mwb_t exp;
		dex_mwb_t care;
		drive_word({5'b01101, immd, field});
		if (immd)
			check_pc(1'b1, pc_plus_1 + {{6{field[9]}}, field});
		else
			check_pc(1'b1, ref_regs[field[4:0]]);
		exp = '0;
		exp.pcr_to_reg = 1'b1;
		exp.reg_we_dst_1 = 1'b1;
		exp.dst_addr_1 = LINK_REG;
		exp.pc_return = pc_plus_1;
		care = ctrl_care();
		care.dst_addr_1 = '1;
		care.pc_return = '1;
		expect_advance(exp, care);
	endtask

	task automatic run_mem(input logic store, input logic [4:0] rs, input logic [4:0] rt);
		dex_mwb_t exp;
		dex_mwb_t care;
		exp = '0;
		care = ctrl_care();
		care.mem_addr = '1;
		care.mem_wdata = '1;
		exp.mem_addr = ref_regs[rt];
		exp.mem_wdata = ref_regs[rs];
		if (store) begin
			exp.mem_we = 1'b1;
		end else begin
			exp.mem_re = 1'b1;
			exp.mem_to_reg = 1'b1;
			exp.reg_we_dst_0 = 1'b1;
			exp.dst_addr_0 = rs;
			care.dst_addr_0 = '1;
		end
		drive_word({4'b0101, store, 1'b0, rs, rt});
		expect_advance(exp, care);
	endtask

	task automatic run_ldi(input logic upper, input logic [2:0] rsel, input logic [7:0] imm8);
		logic [4:0] ra;
		dex_mwb_t exp;
		dex_mwb_t care;
		ra = {2'b00, rsel};
		exp = '0;
		exp.reg_we_dst_0 = 1'b1;
		exp.dst_addr_0 = ra;
		exp.load_immd = upper ? {imm8, ref_regs[ra][7:0]} : {ref_regs[ra][15:8], imm8};
		care = ctrl_care();
		care.dst_addr_0 = '1;
		care.load_immd = '1;
		drive_word({4'b0100, upper, rsel, imm8});
		expect_advance(exp, care);
	endtask

	task automatic count_wait(input logic [10:0] count, input int exp_cycles);
		int cnt;
		cnt = 0;
		drive_word({5'b01110, count});
		while (stall && cnt < 16) begin
			cnt++;
			@(negedge clk);
			#1;
		end
		cmp_field("wait_stall_cycles", 16'(exp_cycles), 16'(cnt));
		expect_advance('0, ctrl_care());
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////
	task automatic test_reset_and_regs();
		logic [15:0] d0;
		logic [15:0] d1;
		logic [15:0] t;
		check_mwb('0, '1);
		check_bit("stall", 1'b0, stall);
		check_bit("vpu_start", 1'b0, vpu_start);
		for (int i = 0; i < 32; i += 2) begin
			d0 = lcg16();
			d1 = lcg16();
			write_pair(5'(i), d0, 5'(i + 1), d1);
		end
		// Same address on both ports
		d0 = lcg16();
		d1 = lcg16();
		write_pair(5'd5, d0, 5'd5, d1);
		run_mem(1'b0, 5'd5, 5'd5);
		for (int i = 0; i < 4; i++) begin
			t = lcg16();
			run_mem(1'b0, t[9:5], t[4:0]);
		end
	endtask

	task automatic test_alu();
		logic [15:0] t;
		alu_op_e op;
		for (int r = 0; r < 2; r++) begin
			for (int k = 0; k < 8; k++) begin
				op = alu_op_e'(k[2:0]);
				t = lcg16();
				run_alu(op, 1'b0, t[9:5], t[4:0]);
				if (k < 2) begin
					t = lcg16();
					run_alu(op, 1'b1, t[9:5], t[4:0]);
				end
			end
		end
	endtask

	task automatic test_branches();
		alu_op_e sit_op [4];
		logic [4:0] sit_rs [4];
		logic [4:0] sit_rt [4];
		logic [15:0] t;
		// Zero, signed overflow to negative, positive, overflow to positive
		sit_op = '{ALU_SUB, ALU_ADD, ALU_ADD, ALU_SUB};
		sit_rs = '{5'd1, 5'd3, 5'd1, 5'd2};
		sit_rt = '{5'd1, 5'd4, 5'd4, 5'd1};
		write_pair(5'd1, 16'h0001, 5'd4, 16'h0001);
		write_pair(5'd2, 16'h8000, 5'd3, 16'h7fff);
		for (int c = 0; c < 8; c++) begin
			for (int s = 0; s < 4; s++) begin
				t = lcg16();
				run_alu(sit_op[s], 1'b0, sit_rs[s], sit_rt[s]);
				run_branch(c[2:0], t[7:0]);
			end
		end
		// AND must leave V set
		run_alu(ALU_ADD, 1'b0, 5'd3, 5'd4);
		run_alu(ALU_AND, 1'b0, 5'd2, 5'd2);
		run_branch(3'd6, 8'h22);
	endtask

	task automatic test_jumps_and_memory();
		logic [15:0] t;
		for (int r = 0; r < 2; r++) begin
			t = lcg16();
			run_jump(1'b1, t[9:0]);
			t = lcg16();
			run_jump(1'b0, t[9:0]);
			t = lcg16();
			run_mem(1'b0, t[9:5], t[4:0]);
			t = lcg16();
			run_mem(1'b1, t[9:5], t[4:0]);
			t = lcg16();
			run_ldi(1'b1, t[10:8], t[7:0]);
			t = lcg16();
			run_ldi(1'b0, t[10:8], t[7:0]);
		end
	endtask

	task automatic test_stalls();
		count_wait(11'd3, 3);
		count_wait(11'd3, 3);
		count_wait(11'd0, 0);

		// ALU result in mwb that the VPU stall has to hold
		run_alu(ALU_XOR, 1'b0, 5'd3, 5'd2);

		// VPU holds until vpu_rdy
		drive_word(VPU_WORD);
		for (int i = 0; i < 4; i++) begin
			check_bit("vpu_start", 1'b1, vpu_start);
			check_bit("stall", 1'b1, stall);
			check_mwb(last_exp, last_care);
			@(negedge clk);
		end
		vpu_rdy = 1'b1;
		#1;
		check_bit("vpu_start", 1'b1, vpu_start);
		check_bit("stall", 1'b0, stall);
		expect_advance('0, ctrl_care());
		@(negedge clk);
		vpu_rdy = 1'b0;

		// Memory stall freezes mwb and flags
		run_alu(ALU_ADD, 1'b0, 5'd3, 5'd4);
		@(negedge clk);
		stall_memory = 1'b1;
		instr = {2'b00, ALU_SUB, 1'b0, 5'd1, 5'd1};
		#1;
		for (int i = 0; i < 3; i++) begin
			check_bit("stall", 1'b1, stall);
			check_mwb(last_exp, last_care);
			@(negedge clk);
		end
		instr = {5'b01100, 3'd1, 8'h10};
		#1;
		check_pc(taken_ref(3'd1), pc_plus_1 + 16'h0010);
		@(negedge clk);
		check_mwb(last_exp, last_care);
		stall_memory = 1'b0;
		run_branch(3'd6, 8'hf0);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		stall_memory = 1'b0;
		instr = NOP_WORD;
		pc_plus_1 = '0;
		wr_0 = '0;
		wr_1 = '0;
		vpu_rdy = 1'b0;
		ref_flags = '0;
		last_exp = '0;
		last_care = '0;
		for (int i = 0; i < 32; i++) begin
			ref_regs[i] = '0;
		end
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		#1;
		test_reset_and_regs();
		test_alu();
		test_branches();
		test_jumps_and_memory();
		test_stalls();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* sources.f */
hw/dex_pkg.sv
hw/alu.sv
hw/register_file.sv
hw/control_unit.sv
hw/branch_unit.sv
hw/decode_execute.sv
bench/tb_decode_execute.sv

/* Makefile */
SIM = obj_dir/Vtb_decode_execute

.PHONY: all run clean

all: run

$(SIM): sources.f $(wildcard hw/*.sv bench/*.sv)
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_decode_execute -f sources.f

run: $(SIM)
	$(SIM) | awk '{ print } /^TESTS PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
